/* graphics_pkg.sv */
// shared raster geometry, opcodes and bus structs, imported by every graphics module
package graphics_pkg;

    // **************************************************************************
    // raster geometry, all horizontal values in clock cycles
    // **************************************************************************
    localparam int H_ACTIVE = 32;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 4;
    localparam int H_BACK   = 8;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;   // 48

    localparam int V_ACTIVE = 16;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 1;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;   // 20 lines

    localparam int PIXEL_COUNT   = H_ACTIVE * V_ACTIVE;   // pixels per bank
    localparam int PALETTE_SIZE  = 16;
    localparam int PIXEL_LATENCY = 3;                      // memory, palette, output reg

    // **************************************************************************
    // command stream
    // **************************************************************************
    typedef enum logic [7:0] {
        OP_ASSIGN_COLOR = 8'h10,
        OP_CLEAR        = 8'h11,
        OP_DRAW_PIXEL   = 8'h12,
        OP_SHOW_BUFFER  = 8'h17
    } opcode_t;

    typedef enum logic [1:0] {
        IDLE,
        ASSIGN,
        DRAW,
        CLEAR_SWEEP
    } decoder_state_t;

    typedef struct packed {
        opcode_t    op_code;
        logic       op_code_valid;
        logic [7:0] operand;
        logic       operand_valid;
        logic [3:0] operand_count;   // first operand is 1
    } command_t;

    typedef struct packed {
        logic [3:0] y;
        logic [2:0] cb;
        logic [2:0] cr;
    } ycbcr_t;

    typedef struct packed {
        logic       enable;
        logic [3:0] index;
        ycbcr_t     color;
    } palette_write_t;

    typedef struct packed {
        logic       valid;
        logic [8:0] addr;
        logic [3:0] index;
    } pixel_write_t;

    typedef struct packed {
        logic       valid;
        logic [8:0] addr;
    } pixel_read_t;

    typedef struct packed {
        logic       enable;
        logic       write;
        logic [8:0] addr;
        logic [3:0] index;
    } memory_access_t;

endpackage

/* command_decoder.sv */
// decodes the host command stream into palette writes, pixel writes and show requests
`timescale 1ns/1ps

module command_decoder import graphics_pkg::*; (
    input  logic           clock_in,
    input  logic           arst_n,
    input  command_t       command,
    output palette_write_t palette_write,
    output pixel_write_t   pixel_write,
    input  logic           write_grant,
    output logic           show_request,
    output logic           command_busy
);

    decoder_state_t state;
    logic           pal_enable;
    logic [3:0]     pal_index;
    ycbcr_t         pal_color;
    logic           wr_valid;
    logic [8:0]     wr_addr;
    logic [3:0]     wr_index;
    logic [7:0]     x_reg;
    logic [7:0]     y_reg;
    logic           show_pulse;
    logic           start;
    logic           in_range;

    assign start    = command.op_code_valid && !command.operand_valid && !wr_valid;
    assign in_range = (x_reg < 8'(H_ACTIVE)) && (y_reg < 8'(V_ACTIVE));

    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            pal_enable <= 1'b0;
            pal_index  <= '0;
            pal_color  <= '0;
            wr_valid   <= 1'b0;
            wr_addr    <= '0;
            wr_index   <= '0;
            x_reg      <= '0;
            y_reg      <= '0;
            show_pulse <= 1'b0;
        end else begin
            pal_enable <= 1'b0;   // single-cycle pulses
            show_pulse <= 1'b0;

            case (state)
                ASSIGN: begin
                    if (command.operand_valid) begin
                        case (command.operand_count)
                            4'd1: pal_index <= command.operand[3:0];
                            4'd2: pal_color.y <= command.operand[7:4];
                            4'd3: pal_color.cb <= command.operand[7:5];
                            4'd4: begin
                                pal_color.cr <= command.operand[7:5];
                                pal_enable   <= 1'b1;
                                state        <= IDLE;
                            end
                            default: ;
                        endcase
                    end
                end
                DRAW: begin
                    if (wr_valid) begin
                        if (write_grant) begin   // hold the request until granted
                            wr_valid <= 1'b0;
                            state    <= IDLE;
                        end
                    end else if (command.operand_valid) begin
                        case (command.operand_count)
                            4'd1: x_reg <= command.operand;
                            4'd2: y_reg <= command.operand;
                            4'd3: begin
                                wr_addr  <= 9'(y_reg * H_ACTIVE + x_reg);
                                wr_index <= command.operand[3:0];
                                wr_valid <= in_range;   // off-screen draws are dropped
                                if (!in_range) state <= IDLE;
                            end
                            default: ;
                        endcase
                    end
                end
                CLEAR_SWEEP: begin
                    if (wr_valid) begin
                        if (write_grant) begin
                            if (wr_addr == 9'(PIXEL_COUNT - 1)) begin
                                wr_valid <= 1'b0;
                                state    <= IDLE;
                            end else begin
                                wr_addr <= wr_addr + 9'd1;   // next pixel of the sweep
                            end
                        end
                    end else if (command.operand_valid && command.operand_count == 4'd1) begin
                        wr_index <= command.operand[3:0];
                        wr_addr  <= '0;
                        wr_valid <= 1'b1;
                    end
                end
                default: ;
            endcase

            // a new opcode replaces any half-assembled command
            if (start) begin
                case (command.op_code)
                    OP_ASSIGN_COLOR: state <= ASSIGN;
                    OP_DRAW_PIXEL:   state <= DRAW;
                    OP_CLEAR:        state <= CLEAR_SWEEP;
                    OP_SHOW_BUFFER: begin
                        state      <= IDLE;
                        show_pulse <= 1'b1;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    assign palette_write = '{enable: pal_enable, index: pal_index, color: pal_color};
    assign pixel_write   = '{valid: wr_valid, addr: wr_addr, index: wr_index};
    assign show_request  = show_pulse;
    assign command_busy  = wr_valid;

endmodule

/* color_palette.sv */
// indexed color lookup table, written by the command decoder and read every display cycle
`timescale 1ns/1ps

module color_palette import graphics_pkg::*; (
    input  logic           clock_in,
    input  logic           arst_n,
    input  palette_write_t palette_write,
    input  logic [3:0]     read_index,
    output ycbcr_t         color
);

    ycbcr_t entries [PALETTE_SIZE];

    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < PALETTE_SIZE; i++) begin
                entries[i] <= '0;   // all entries black
            end
            color <= '0;
        end else begin
            if (palette_write.enable) begin
                entries[palette_write.index] <= palette_write.color;
            end
            color <= entries[read_index];   // registered lookup, one cycle
        end
    end

endmodule

/* frame_buffer_arbiter.sv */
// shares the single frame buffer port between display reads and decoder pixel writes
`timescale 1ns/1ps

module frame_buffer_arbiter import graphics_pkg::*; (
    input  pixel_read_t    pixel_read,
    input  pixel_write_t   pixel_write,
    output logic           write_grant,
    output memory_access_t memory_access
);

    // the display can never wait, so a write only goes out in a free cycle
    assign write_grant = pixel_write.valid && !pixel_read.valid;

    always_comb begin
        memory_access.enable = pixel_read.valid || pixel_write.valid;
        memory_access.write  = write_grant;
        memory_access.addr   = pixel_read.valid ? pixel_read.addr : pixel_write.addr;
        memory_access.index  = pixel_write.index;   // ignored on reads
    end

endmodule

/* frame_buffers.sv */
// double-buffered pixel memory, display reads the front bank while writes go to the back
`timescale 1ns/1ps

module frame_buffers import graphics_pkg::*; (
    input  logic           clock_in,
    input  logic           arst_n,
    input  memory_access_t memory_access,
    input  logic           show_request,
    input  logic           frame_end,
    output logic [3:0]     read_index
);

    logic [3:0] mem [2 * PIXEL_COUNT];   // bank bit on top of the pixel address
    logic       front_bank;
    logic       swap_pending;

    // **************************************************************************
    // single port array
    // **************************************************************************
    always_ff @(posedge clock_in) begin
        if (memory_access.enable) begin
            if (memory_access.write) begin
                mem[{~front_bank, memory_access.addr}] <= memory_access.index;
            end else begin
                read_index <= mem[{front_bank, memory_access.addr}];
            end
        end
    end

    // **************************************************************************
    // bank swap, deferred to the last cycle of the frame
    // **************************************************************************
    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            front_bank   <= 1'b0;
            swap_pending <= 1'b0;
        end else begin
            swap_pending <= (swap_pending && !frame_end) || show_request;
            if (frame_end && swap_pending) begin
                front_bank <= ~front_bank;   // old front becomes the new back
            end
        end
    end

endmodule

/* display_driver.sv */
// raster timing generator that fetches pixels and drives the sync and YCbCr panel outputs
`timescale 1ns/1ps

module display_driver import graphics_pkg::*; (
    input  logic        clock_in,
    input  logic        arst_n,
    output pixel_read_t pixel_read,
    output logic        frame_end,
    input  ycbcr_t      color,
    output logic        display_clock_out,
    output logic        display_hsync,
    output logic        display_vsync,
    output logic [3:0]  display_y,
    output logic [2:0]  display_cb,
    output logic [2:0]  display_cr
);

    logic [5:0] h_count;
    logic [4:0] v_count;
    logic       active;
    logic       hsync_n;
    logic       vsync_n;
    logic       line_end;

    logic [PIXEL_LATENCY-1:0] active_pipe;
    logic [PIXEL_LATENCY-1:0] hsync_pipe;
    logic [PIXEL_LATENCY-1:0] vsync_pipe;

    // **************************************************************************
    // raster counters
    // **************************************************************************
    assign line_end  = (h_count == 6'(H_TOTAL - 1));
    assign frame_end = line_end && (v_count == 5'(V_TOTAL - 1));

    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            h_count <= '0;
            v_count <= '0;
        end else if (line_end) begin
            h_count <= '0;
            v_count <= frame_end ? '0 : v_count + 5'd1;
        end else begin
            h_count <= h_count + 6'd1;
        end
    end

    assign active  = (h_count < 6'(H_ACTIVE)) && (v_count < 5'(V_ACTIVE));
    assign hsync_n = !((h_count >= 6'(H_ACTIVE + H_FRONT)) &&
                       (h_count <  6'(H_ACTIVE + H_FRONT + H_SYNC)));
    assign vsync_n = !((v_count >= 5'(V_ACTIVE + V_FRONT)) &&
                       (v_count <  5'(V_ACTIVE + V_FRONT + V_SYNC)));

    // linear address y*32+x for every active pixel
    assign pixel_read = '{valid: active, addr: {v_count[3:0], h_count[4:0]}};

    // **************************************************************************
    // delay line matching memory, palette and output register latency
    // **************************************************************************
    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            active_pipe <= '0;
            hsync_pipe  <= '1;   // syncs idle high
            vsync_pipe  <= '1;
            display_y   <= '0;
            display_cb  <= '0;
            display_cr  <= '0;
        end else begin
            active_pipe <= {active_pipe[PIXEL_LATENCY-2:0], active};
            hsync_pipe  <= {hsync_pipe[PIXEL_LATENCY-2:0], hsync_n};
            vsync_pipe  <= {vsync_pipe[PIXEL_LATENCY-2:0], vsync_n};
            display_y   <= active_pipe[PIXEL_LATENCY-2] ? color.y  : '0;   // blank outside data
            display_cb  <= active_pipe[PIXEL_LATENCY-2] ? color.cb : '0;
            display_cr  <= active_pipe[PIXEL_LATENCY-2] ? color.cr : '0;
        end
    end

    assign display_clock_out = active_pipe[PIXEL_LATENCY-1];
    assign display_hsync     = hsync_pipe[PIXEL_LATENCY-1];
    assign display_vsync     = vsync_pipe[PIXEL_LATENCY-1];

endmodule

/* graphics.sv */
// graphics subsystem top level, wires the command decoder to the double-buffered display path
`timescale 1ns/1ps

module graphics import graphics_pkg::*; (
    input  logic       clock_in,
    input  logic       arst_n,
    input  command_t   command,
    output logic       command_busy,
    output logic       display_clock_out,
    output logic       display_hsync,
    output logic       display_vsync,
    output logic [3:0] display_y,
    output logic [2:0] display_cb,
    output logic [2:0] display_cr
);

    palette_write_t palette_write;
    pixel_write_t   pixel_write;
    pixel_read_t    pixel_read;
    memory_access_t memory_access;
    logic           write_grant;
    logic           show_request;
    logic           frame_end;
    logic [3:0]     read_index;
    ycbcr_t         color;

    command_decoder command_decoder_i (
        .clock_in      (clock_in),
        .arst_n        (arst_n),
        .command       (command),
        .palette_write (palette_write),
        .pixel_write   (pixel_write),
        .write_grant   (write_grant),
        .show_request  (show_request),
        .command_busy  (command_busy)
    );

    frame_buffer_arbiter frame_buffer_arbiter_i (
        .pixel_read    (pixel_read),
        .pixel_write   (pixel_write),
        .write_grant   (write_grant),
        .memory_access (memory_access)
    );

    frame_buffers frame_buffers_i (
        .clock_in      (clock_in),
        .arst_n        (arst_n),
        .memory_access (memory_access),
        .show_request  (show_request),
        .frame_end     (frame_end),
        .read_index    (read_index)
    );

    color_palette color_palette_i (
        .clock_in      (clock_in),
        .arst_n        (arst_n),
        .palette_write (palette_write),
        .read_index    (read_index),
        .color         (color)
    );

    display_driver display_driver_i (
        .clock_in          (clock_in),
        .arst_n            (arst_n),
        .pixel_read        (pixel_read),
        .frame_end         (frame_end),
        .color             (color),
        .display_clock_out (display_clock_out),
        .display_hsync     (display_hsync),
        .display_vsync     (display_vsync),
        .display_y         (display_y),
        .display_cb        (display_cb),
        .display_cr        (display_cr)
    );

endmodule

/* graphics_props.sv */
// bound assertions on display sync pulse widths and on pixel writes held back by display reads
`timescale 1ns/1ps

module graphics_props import graphics_pkg::*; (
    input logic         clock_in,
    input logic         arst_n,
    input logic         display_hsync,
    input logic         display_vsync,
    input pixel_read_t  pixel_read,
    input pixel_write_t pixel_write
);

    int hsync_low;   // cycles the sync has been low so far
    int vsync_low;

    always_ff @(posedge clock_in or negedge arst_n) begin
        if (!arst_n) begin
            hsync_low <= 0;
            vsync_low <= 0;
        end else begin
            hsync_low <= display_hsync ? 0 : hsync_low + 1;
            vsync_low <= display_vsync ? 0 : vsync_low + 1;
        end
    end

    hsync_width: assert property (@(posedge clock_in) disable iff (!arst_n)
        $rose(display_hsync) |-> hsync_low == H_SYNC)
        else $error("hsync pulse has the wrong width");

    vsync_width: assert property (@(posedge clock_in) disable iff (!arst_n)
        $rose(display_vsync) |-> vsync_low == V_SYNC * H_TOTAL)
        else $error("vsync pulse has the wrong width");

    // a write that meets a display read waits with its address and index unchanged
    read_priority: assert property (@(posedge clock_in) disable iff (!arst_n)
        pixel_write.valid && pixel_read.valid |=> pixel_write.valid &&
            $stable(pixel_write.addr) && $stable(pixel_write.index))
        else $error("pixel write granted or changed while the display was reading");

endmodule

// checks on every instance of the graphics top level
bind graphics graphics_props props_i (
    .clock_in      (clock_in),
    .arst_n        (arst_n),
    .display_hsync (display_hsync),
    .display_vsync (display_vsync),
    .pixel_read    (pixel_read),
    .pixel_write   (pixel_write)
);

/* graphics_tb.sv */
// testbench that runs a command table through the graphics top level against a screen model
`timescale 1ns/1ps

module graphics_tb import graphics_pkg::*; ();

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;   // 960

    typedef struct packed {
        opcode_t         op;
        logic [0:3][7:0] operands;   // operand 1 on the left
        logic            while_busy; // sent without waiting so it must be ignored
    } table_cmd_t;

    logic       clock_in;
    logic       arst_n;
    command_t   command;
    logic       command_busy;
    logic       display_clock_out;
    logic       display_hsync;
    logic       display_vsync;
    logic [3:0] display_y;
    logic [2:0] display_cb;
    logic [2:0] display_cr;

    ycbcr_t     model_palette [PALETTE_SIZE];
    logic [3:0] model_bank [2][PIXEL_COUNT];
    int         model_front;
    table_cmd_t cmds [$];
    string      test_name [$];
    int         test_first [$];
    int         test_count [$];
    int         test_frames [$];
    int         table_frames = 0;
    int         seed = 37;
    int         cycles = 0;
    int         cycle_limit = 0;
    int         checks = 0;
    int         errors = 0;
    int         clear_cycle = -1;   // cycle of the last clear or -1 when none is open

    graphics dut_i (
        .clock_in          (clock_in),
        .arst_n            (arst_n),
        .command           (command),
        .command_busy      (command_busy),
        .display_clock_out (display_clock_out),
        .display_hsync     (display_hsync),
        .display_vsync     (display_vsync),
        .display_y         (display_y),
        .display_cb        (display_cb),
        .display_cr        (display_cr)
    );

    initial begin
        clock_in = 1'b0;
        forever #5 clock_in = ~clock_in;
    end

    always @(posedge clock_in) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the display or the decoder stopped", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ************************************************************************
    // compare tasks
    // ************************************************************************
    task automatic compare_color(input ycbcr_t actual, input ycbcr_t expected, input string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %0t %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic compare_sync(input logic actual, input logic expected, input string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %0t %s got %b expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic compare_busy(input logic actual, input logic expected, input string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %0t %s got %b expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic compare_count(input int actual, input int expected, input string name);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("MISMATCH %0t %s got %0d expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: FAIL with %0d errors", name, errors - err_before);
        end
    endtask

    // ************************************************************************
    // test table
    // ************************************************************************
    task automatic open_test(input string name);
        test_name.push_back(name);
        test_first.push_back(cmds.size());
    endtask

    task automatic add_command(input opcode_t op, input logic [31:0] bytes, input logic busy);
        cmds.push_back('{op: op, operands: bytes, while_busy: busy});
    endtask

    task automatic close_test(input int frames);
        int clears;
        clears = 0;
        for (int i = test_first[$]; i < cmds.size(); i++) begin
            if (cmds[i].op == OP_CLEAR) begin
                clears++;
            end
        end
        test_count.push_back(cmds.size() - test_first[$]);
        test_frames.push_back(frames);
        table_frames += frames + 2 + 2 * clears;   // capture wait, draws, clear sweeps
    endtask

    task automatic build_table();
        int x;
        int y;
        int c;
        int first_x;
        int first_y;
        int first_c;
        first_x = 0;
        first_y = 0;
        first_c = 1;
        open_test("clear and show");
        for (int i = 0; i < PALETTE_SIZE; i++) begin
            add_command(OP_ASSIGN_COLOR,
                        {8'(i), 8'(i << 4), 8'((i * 3) << 5), 8'((i + 5) << 5)}, 1'b0);
        end
        add_command(OP_CLEAR, {8'd5, 24'h0}, 1'b0);
        add_command(OP_SHOW_BUFFER, 32'h0, 1'b0);
        close_test(2);

        open_test("random pixel draws");
        add_command(OP_CLEAR, 32'h0, 1'b0);
        for (int i = 0; i < 12; i++) begin
            x = $unsigned($random(seed)) % H_ACTIVE;
            y = $unsigned($random(seed)) % V_ACTIVE;
            c = 1 + $unsigned($random(seed)) % 15;   // never palette 0 which is the background
            if (i == 0) begin
                first_x = x;
                first_y = y;
                first_c = c;
            end
            add_command(OP_DRAW_PIXEL, {8'(x), 8'(y), 8'(c), 8'h0}, 1'b0);
        end
        add_command(OP_DRAW_PIXEL,
                    {8'(first_x), 8'(first_y), 8'((first_c % 15) + 1), 8'h0}, 1'b0);
        add_command(OP_SHOW_BUFFER, 32'h0, 1'b0);
        close_test(2);

        open_test("back buffer draws and dropped commands");
        add_command(OP_CLEAR, {8'd9, 24'h0}, 1'b0);
        add_command(OP_DRAW_PIXEL, {8'd0, 8'd0, 8'd3, 8'h0}, 1'b1);   // lands in the sweep
        add_command(OP_DRAW_PIXEL, {8'd1, 8'd1, 8'd4, 8'h0}, 1'b0);
        add_command(OP_DRAW_PIXEL, {8'd2, 8'd1, 8'd5, 8'h0}, 1'b0);
        add_command(OP_DRAW_PIXEL, {8'd31, 8'd15, 8'd6, 8'h0}, 1'b0);
        add_command(OP_DRAW_PIXEL, {8'd40, 8'd3, 8'd7, 8'h0}, 1'b0);
        add_command(OP_DRAW_PIXEL, {8'd3, 8'd20, 8'd7, 8'h0}, 1'b0);
        close_test(1);

        open_test("show after back buffer draws");
        add_command(OP_SHOW_BUFFER, 32'h0, 1'b0);
        close_test(1);

        open_test("palette change");
        add_command(OP_ASSIGN_COLOR, {8'd9, 8'h20, 8'he0, 8'h20}, 1'b0);
        add_command(OP_ASSIGN_COLOR, {8'd4, 8'hc0, 8'h40, 8'hc0}, 1'b0);
        close_test(2);
    endtask

    // ************************************************************************
    // command driver and screen model
    // ************************************************************************
    task automatic next_cycle();
        @(posedge clock_in);
        #1;
    endtask

    function automatic int operand_total(input opcode_t op);
        case (op)
            OP_ASSIGN_COLOR: return 4;
            OP_CLEAR:        return 1;
            OP_DRAW_PIXEL:   return 3;
            default:         return 0;
        endcase
    endfunction

    task automatic wait_idle();
        while (command_busy) begin
            next_cycle();
        end
        if (clear_cycle >= 0) begin
            checks++;
            if (cycles - clear_cycle > 2 * FRAME_CYCLES) begin
                errors++;
                $display("clear took %0d cycles, busy did not fall within two frames",
                         cycles - clear_cycle);
            end
            clear_cycle = -1;
        end
    endtask

    task automatic send_command(input table_cmd_t c);
        if (c.while_busy) begin
            compare_busy(command_busy, 1'b1, "command_busy");
        end else begin
            wait_idle();
        end
        command = '{op_code: c.op, op_code_valid: 1'b1, operand: 8'h0,
                    operand_valid: 1'b0, operand_count: 4'd0};
        next_cycle();
        for (int i = 0; i < operand_total(c.op); i++) begin
            command = '{op_code: c.op, op_code_valid: 1'b0, operand: c.operands[i],
                        operand_valid: 1'b1, operand_count: 4'(i + 1)};
            next_cycle();
        end
        command = '0;
        if (c.op == OP_CLEAR && !c.while_busy) begin
            clear_cycle = cycles;
        end
    endtask

    task automatic apply_model(input table_cmd_t c);
        if (!c.while_busy) begin
            case (c.op)
                OP_ASSIGN_COLOR: model_palette[c.operands[0][3:0]] = '{y: c.operands[1][7:4],
                    cb: c.operands[2][7:5], cr: c.operands[3][7:5]};
                OP_CLEAR: begin
                    for (int p = 0; p < PIXEL_COUNT; p++) begin
                        model_bank[1 - model_front][p] = c.operands[0][3:0];
                    end
                end
                OP_DRAW_PIXEL: begin
                    if (c.operands[0] < H_ACTIVE && c.operands[1] < V_ACTIVE) begin
                        model_bank[1 - model_front][c.operands[1] * H_ACTIVE + c.operands[0]] =
                            c.operands[2][3:0];
                    end
                end
                default: model_front = 1 - model_front;   // show swaps the banks
            endcase
        end
    endtask

    // ************************************************************************
    // capture of the panel outputs
    // ************************************************************************
    task automatic wait_vsync_fall();
        logic prev;
        prev = display_vsync;
        next_cycle();
        while (!(prev && !display_vsync)) begin
            prev = display_vsync;
            next_cycle();
        end
    endtask

    task automatic capture_frame();
        int     count;
        ycbcr_t shown;
        count = 0;
        wait_vsync_fall();   // the next 512 strobes belong to one frame
        while (count < PIXEL_COUNT) begin
            next_cycle();
            shown = '{y: display_y, cb: display_cb, cr: display_cr};
            if (display_clock_out) begin
                compare_color(shown, model_palette[model_bank[model_front][count]],
                              $sformatf("display_color[%0d]", count));
                count++;
            end else begin
                compare_color(shown, ycbcr_t'(0), "display_color blank");
            end
        end
    endtask

    task automatic check_sync_timing();
        int   frame_len;
        int   strobes;
        int   line_strobes;
        int   hlow;
        int   last_hfall;
        logic hprev;
        logic vprev;
        logic done;
        frame_len = 0;
        strobes = 0;
        line_strobes = 0;
        hlow = 0;
        last_hfall = -1;
        done = 1'b0;
        wait_vsync_fall();
        hprev = display_hsync;
        vprev = display_vsync;
        while (!done) begin
            next_cycle();
            frame_len++;
            if (display_clock_out) begin
                strobes++;
                line_strobes++;
            end
            if (!display_hsync) begin
                hlow++;
            end
            if (hprev && !display_hsync) begin
                if (last_hfall >= 0) begin
                    compare_count(frame_len - last_hfall, H_TOTAL, "hsync period");
                end
                if (line_strobes != 0) begin
                    compare_count(line_strobes, H_ACTIVE, "strobes per line");
                end
                last_hfall = frame_len;
                line_strobes = 0;
            end
            if (!hprev && display_hsync) begin
                compare_count(hlow, H_SYNC, "hsync low cycles");
                hlow = 0;
            end
            done = vprev && !display_vsync;
            hprev = display_hsync;
            vprev = display_vsync;
        end
        compare_count(frame_len, FRAME_CYCLES, "vsync period");
        compare_count(strobes, PIXEL_COUNT, "strobes per frame");
    endtask

    initial begin
        int err_before;
        arst_n = 1'b0;
        command = '0;
        model_front = 0;
        for (int i = 0; i < PALETTE_SIZE; i++) begin
            model_palette[i] = '0;
        end
        for (int p = 0; p < PIXEL_COUNT; p++) begin
            model_bank[0][p] = '0;
            model_bank[1][p] = '0;
        end
        build_table();
        cycle_limit = (table_frames + 4) * FRAME_CYCLES;

        repeat (4) @(posedge clock_in);
        #1;
        err_before = errors;
        compare_sync(display_hsync, 1'b1, "display_hsync");
        compare_sync(display_vsync, 1'b1, "display_vsync");
        compare_sync(display_clock_out, 1'b0, "display_clock_out");
        compare_color(ycbcr_t'({display_y, display_cb, display_cr}), ycbcr_t'(0),
                      "display_color");
        compare_busy(command_busy, 1'b0, "command_busy");
        next_cycle();
        arst_n = 1'b1;   // released after the fifth edge
        report_test("reset values", err_before);

        err_before = errors;
        check_sync_timing();
        report_test("sync timing", err_before);

        for (int t = 0; t < test_name.size(); t++) begin
            err_before = errors;
            for (int i = test_first[t]; i < test_first[t] + test_count[t]; i++) begin
                send_command(cmds[i]);
                apply_model(cmds[i]);
            end
            wait_idle();
            repeat (test_frames[t]) capture_frame();
            report_test(test_name[t], err_before);
        end

        $display("tests %0d, checks %0d, errors %0d", test_name.size() + 2, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* graphics.f */
graphics_pkg.sv
command_decoder.sv
color_palette.sv
frame_buffer_arbiter.sv
frame_buffers.sv
display_driver.sv
graphics.sv
graphics_props.sv
graphics_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module graphics_tb -f graphics.f
./obj_dir/Vgraphics_tb | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
